/* filelist.f */
hdl/boothArithPkg.sv
hdl/mulPipePkg.sv
hdl/boothDigitEncoder.sv
hdl/boothPpStage.sv
hdl/wallaceReducer.sv
hdl/mulPipeCtrl.sv
hdl/boothMulTop.sv
sim/tbBoothMul.sv

/* run.sh */
#!/bin/sh
# Build and run the Booth multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbBoothMul -f filelist.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOut=$(./obj_dir/VtbBoothMul)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "No errors"; then
    exit 0
fi
exit 1

/* sim/tbBoothMul.sv */
`timescale 1ns/1ps
`default_nettype none

module tbBoothMul;

    localparam int maxCycles = 6000;    // Tests need about 1500 cycles
    localparam int numRandom = 300;

    logic                   clk;
    logic                   rstN;
    logic                   reqValid;
    logic                   reqReady;
    mulPipePkg::mulReqT     req;
    logic                   resValid;
    logic                   resReady;
    boothArithPkg::productT res;

    boothArithPkg::productT expQ [$];       // Products still owed by the DUT
    int                     resCycleQ [$];  // Cycle of each taken result
    boothArithPkg::productT expected;
    boothArithPkg::productT heldRes;        // res seen at the last stalled cycle
    logic                   wasStalled;
    int                     cycleCount;
    int                     errorCount;
    int                     checkCount;
    int                     testCount;

    boothMulTop DUT (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .resValid (resValid),
        .resReady (resReady),
        .res      (res)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
    end

    // Signed 64-bit reference product
    function automatic boothArithPkg::productT refProduct(
        input boothArithPkg::operandT a,
        input boothArithPkg::operandT b
    );
        logic signed [63:0] wideA;
        logic signed [63:0] wideB;
        wideA = 64'(a);
        wideB = 64'(b);
        return wideA * wideB;
    endfunction

    // Result side monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rstN) begin
            if (wasStalled) begin
                checkCount++;
                assert (resValid === 1'b1 && res === heldRes) else begin
                    $display("MISMATCH at %0t ns: stalled result moved from %h to %h",
                             $time, heldRes, res);
                    errorCount++;
                end
            end
            if (resValid && !resReady) begin
                checkCount++;
                assert (reqReady === 1'b0) else begin
                    $display("MISMATCH at %0t ns: reqReady high while the result is stalled",
                             $time);
                    errorCount++;
                end
            end
            if (resValid && resReady) begin
                if (expQ.size() == 0) begin
                    $display("Result %h at %0t ns with no request pending", res, $time);
                    errorCount++;
                end else begin
                    expected = expQ.pop_front();
                    resCycleQ.push_back(cycleCount);
                    checkCount++;
                    assert (res === expected) else begin
                        $display("MISMATCH at %0t ns: result %h, expected %h",
                                 $time, res, expected);
                        errorCount++;
                    end
                end
            end
            wasStalled = resValid && !resReady;
            heldRes    = res;
        end
    end

    // Called at posedge+1, returns at posedge+1 after the accepting edge
    task automatic sendReq(
        input  boothArithPkg::operandT a,
        input  boothArithPkg::operandT b,
        output int                     acceptCycle
    );
        reqValid = 1'b1;
        req.opA  = a;
        req.opB  = b;
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
        acceptCycle = cycleCount;      // Cycle in which the handshake holds
        expQ.push_back(refProduct(a, b));
        @(posedge clk);
        #1;
    endtask

    task automatic drainResults();
        reqValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testCount++;
        if (errorCount == errBefore) begin
            $display("Test %-12s passed", name);
        end else begin
            $display("Test %-12s failed with %0d errors", name, errorCount - errBefore);
        end
    endtask

    task automatic checkIdle(input string phase);
        checkCount++;
        assert (resValid === 1'b0 && reqReady === 1'b1) else begin
            $display("MISMATCH at %0t ns: pipeline not idle %s, resValid=%b reqReady=%b",
                     $time, phase, resValid, reqReady);
            errorCount++;
        end
    endtask

    task automatic resetTest();
        int errBefore;
        errBefore = errorCount;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            checkIdle("during reset");
        end
        rstN = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkIdle("after reset");   // resReady still low here
        end
        @(posedge clk);
        #1;
        resReady = 1'b1;
        finishTest("reset", errBefore);
    endtask

    task automatic cornerTest();
        boothArithPkg::operandT maxV;
        boothArithPkg::operandT minV;
        boothArithPkg::operandT negOne;
        boothArithPkg::operandT someV;
        boothArithPkg::operandT patterns [3];
        boothArithPkg::operandT cands [5];
        int                     acc;
        int                     errBefore;
        errBefore = errorCount;
        maxV   = 32'h7FFF_FFFF;
        minV   = 32'h8000_0000;
        negOne = 32'hFFFF_FFFF;
        someV  = 32'h1234_5679;
        patterns[0] = 32'h5555_5555;   // Dense nonzero digits
        patterns[1] = 32'hAAAA_AAAA;
        patterns[2] = 32'h3333_3333;
        cands[0] = 32'h0000_0001;
        cands[1] = negOne;
        cands[2] = maxV;
        cands[3] = minV;
        cands[4] = someV;
        sendReq(32'h0000_0000, someV, acc);
        sendReq(32'h0000_0001, someV, acc);
        sendReq(negOne, negOne, acc);
        sendReq(maxV, maxV, acc);
        sendReq(minV, minV, acc);
        sendReq(minV, maxV, acc);
        sendReq(negOne, minV, acc);
        for (int p = 0; p < 3; p++) begin
            for (int c = 0; c < 5; c++) begin
                sendReq(cands[c], patterns[p], acc);
            end
        end
        drainResults();
        finishTest("corners", errBefore);
    endtask

    task automatic latencyTest();
        int acc;
        int latency;
        int errBefore;
        errBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            resCycleQ.delete();
            sendReq($urandom, $urandom, acc);
            reqValid = 1'b0;
            while (resCycleQ.size() == 0) begin
                @(negedge clk);
            end
            latency = resCycleQ[0] - acc;
            checkCount++;
            assert (latency == 3) else begin
                $display("MISMATCH at %0t ns: result after %0d cycles, expected 3",
                         $time, latency);
                errorCount++;
            end
            @(posedge clk);
            #1;
        end
        finishTest("latency", errBefore);
    endtask

    task automatic streamTest();
        int acc;
        int gaps;
        int errBefore;
        errBefore = errorCount;
        gaps = 0;
        resCycleQ.delete();
        for (int i = 0; i < numRandom; i++) begin
            sendReq($urandom, $urandom, acc);
        end
        drainResults();
        for (int i = 1; i < resCycleQ.size(); i++) begin
            if (resCycleQ[i] != resCycleQ[i-1] + 1) begin
                gaps++;
            end
        end
        checkCount++;
        assert (resCycleQ.size() == numRandom && gaps == 0) else begin
            $display("MISMATCH at %0t ns: %0d results with %0d gaps, expected %0d in a row",
                     $time, resCycleQ.size(), gaps, numRandom);
            errorCount++;
        end
        finishTest("streaming", errBefore);
    endtask

    task automatic backPressureTest();
        boothArithPkg::operandT opsA [numRandom];
        boothArithPkg::operandT opsB [numRandom];
        int                     acc;
        int                     errBefore;
        bit                     sendDone;
        errBefore = errorCount;
        sendDone  = 1'b0;
        resCycleQ.delete();
        for (int i = 0; i < numRandom; i++) begin
            opsA[i] = $urandom;
            opsB[i] = $urandom;
        end
        fork
            begin
                for (int i = 0; i < numRandom; i++) begin
                    sendReq(opsA[i], opsB[i], acc);
                end
                reqValid = 1'b0;
                sendDone = 1'b1;
            end
            begin
                while (!sendDone || expQ.size() != 0) begin
                    resReady = $urandom_range(0, 1) == 1;   // Random stalls
                    @(posedge clk);
                    #1;
                end
            end
        join
        resReady = 1'b1;
        // Every request is answered, so the pipe must stay empty now
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkCount++;
            assert (resValid === 1'b0) else begin
                $display("Extra result %h came out after the last request at %0t ns",
                         res, $time);
                errorCount++;
            end
        end
        @(posedge clk);
        #1;
        finishTest("backpressure", errBefore);
    endtask

    initial begin
        wait (cycleCount >= maxCycles);
        $display("Timeout after %0d cycles, the DUT stopped responding", maxCycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int seedDummy;
        clk        = 1'b0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        req        = '0;
        resReady   = 1'b0;
        wasStalled = 1'b0;
        heldRes    = '0;
        expected   = '0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        seedDummy  = $urandom(57);

        resetTest();
        cornerTest();
        latencyTest();
        streamTest();
        backPressureTest();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/boothMulTop.sv */
`timescale 1ns/1ps
`default_nettype none

// Pipelined signed 32x32 Booth/Wallace multiplier
// Stages: partial products, mid-tree, result
module boothMulTop (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     reqValid,
    output logic                    reqReady,
    input  wire mulPipePkg::mulReqT req,
    output logic                    resValid,
    input  wire                     resReady,
    output boothArithPkg::productT  res
);

    logic              s1Load;      // Load partial products
    logic              s2Load;      // Load mid-tree
    logic              s3Load;      // Load result
    mulPipePkg::ppSetT ppSet;

    mulPipeCtrl uCtrl (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .resValid (resValid),
        .resReady (resReady),
        .s1Load   (s1Load),
        .s2Load   (s2Load),
        .s3Load   (s3Load)
    );

    boothPpStage uPpStage (
        .clk   (clk),
        .rstN  (rstN),
        .load  (s1Load),
        .req   (req),
        .ppSet (ppSet)
    );

    wallaceReducer uReducer (
        .clk     (clk),
        .rstN    (rstN),
        .midLoad (s2Load),
        .outLoad (s3Load),
        .ppSet   (ppSet),
        .res     (res)
    );

endmodule

`default_nettype wire

/* hdl/mulPipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Valid tracking and stall control for the three-stage pipe
module mulPipeCtrl (
    input  wire  clk,
    input  wire  rstN,
    input  wire  reqValid,
    output logic reqReady,
    output logic resValid,
    input  wire  resReady,
    output logic s1Load,
    output logic s2Load,
    output logic s3Load
);

    logic s1Valid;      // Partial products held
    logic s2Valid;      // Mid-tree held
    logic s3Valid;      // Result held
    logic advance;      // Whole pipe moves this cycle

    assign advance  = !s3Valid || resReady;
    assign reqReady = advance;
    assign resValid = s3Valid;

    assign s1Load = advance && reqValid;
    assign s2Load = advance && s1Valid;
    assign s3Load = advance && s2Valid;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else if (advance) begin
            s1Valid <= reqValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    resHeldUntilTaken: assert property (
        @(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid
    ) else $error("resValid dropped before the result was taken");

    // A stall freezes the valid bit of every stage
    stallFreezes: assert property (
        @(posedge clk) disable iff (!rstN)
        !advance |=> $stable({s1Valid, s2Valid, s3Valid})
    ) else $error("Pipeline moved while stalled");

    emptyAccepts: assert property (
        @(posedge clk) disable iff (!rstN)
        !(s1Valid || s2Valid || s3Valid) && reqValid |=> s1Valid
    ) else $error("Empty pipeline refused a request");

endmodule

`default_nettype wire

/* hdl/wallaceReducer.sv */
`timescale 1ns/1ps
`default_nettype none

// Stages 2 and 3 of the multiplier
// Levels 1-3 of the Wallace tree, a register, then levels 4-6 and the final add
module wallaceReducer (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    midLoad,
    input  wire                    outLoad,
    input  wire mulPipePkg::ppSetT ppSet,
    output boothArithPkg::productT res
);

    // 3:2 compressor over 64 bits, carry returned pre-shifted
    function automatic mulPipePkg::csaPairT csa3(
        input boothArithPkg::productT a,
        input boothArithPkg::productT b,
        input boothArithPkg::productT c
    );
        boothArithPkg::productT maj;
        mulPipePkg::csaPairT    pair;
        maj        = (a & b) | (a & c) | (b & c);
        pair.sum   = a ^ b ^ c;
        pair.carry = {maj[boothArithPkg::prodWidth-2:0], 1'b0};
        return pair;
    endfunction

    mulPipePkg::csaPairT l1 [0:4];      // 15 rows to 10
    mulPipePkg::csaPairT l2 [0:2];      // 9 of those to 6
    mulPipePkg::csaPairT l3 [0:1];      // 6 to 4
    mulPipePkg::midTreeT midNext;
    mulPipePkg::midTreeT midReg;
    mulPipePkg::csaPairT l4 [0:1];
    mulPipePkg::csaPairT l5;
    mulPipePkg::csaPairT l6;

    // Front half of the tree
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            l1[i] = csa3(ppSet[3*i], ppSet[3*i+1], ppSet[3*i+2]);
        end

        l2[0] = csa3(l1[0].sum,   l1[0].carry, l1[1].sum);
        l2[1] = csa3(l1[1].carry, l1[2].sum,   l1[2].carry);
        l2[2] = csa3(l1[3].sum,   l1[3].carry, l1[4].sum);

        l3[0] = csa3(l2[0].sum,   l2[0].carry, l2[1].sum);
        l3[1] = csa3(l2[1].carry, l2[2].sum,   l2[2].carry);

        midNext.lvl3A       = l3[0];
        midNext.lvl3B       = l3[1];
        midNext.carryL1Last = l1[4].carry;  // Skips levels 2 and 3
        midNext.pp15        = ppSet[15];
    end

    always_ff @(posedge clk) begin
        if (midLoad) begin
            midReg <= midNext;
        end
    end

    // Back half of the tree
    always_comb begin
        l4[0] = csa3(midReg.lvl3A.sum,   midReg.lvl3A.carry,  midReg.lvl3B.sum);
        l4[1] = csa3(midReg.lvl3B.carry, midReg.carryL1Last, midReg.pp15);

        l5 = csa3(l4[0].sum, l4[0].carry, l4[1].sum);

        l6 = csa3(l5.sum, l5.carry, l4[1].carry);   // Last two rows
    end

    // Carry-propagate add into the result register
    always_ff @(posedge clk) begin
        if (outLoad) begin
            res <= l6.sum + l6.carry;
        end
    end

    // Stage 1 only hands over valid data, so X here means a broken upstream stage
    midNoUnknown: assert property (
        @(posedge clk) disable iff (!rstN)
        midLoad |-> !$isunknown(midNext)
    ) else $error("Mid-tree register loaded with unknown bits");

endmodule

`default_nettype wire

/* hdl/boothPpStage.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage 1: Booth recoding and the partial-product register
module boothPpStage (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     load,
    input  wire mulPipePkg::mulReqT req,
    output mulPipePkg::ppSetT       ppSet
);

    logic [boothArithPkg::opWidth:0] multExt;   // Multiplier with implicit zero below bit 0
    mulPipePkg::ppSetT               ppComb;

    assign multExt = {req.opB, 1'b0};

    // Group i covers multiplier bits 2i+1 .. 2i-1
    for (genvar i = 0; i < boothArithPkg::numPp; i++) begin : genEnc
        boothDigitEncoder uEnc (
            .grp          (multExt[2*i +: 3]),
            .idx          (boothArithPkg::digitIdxT'(i)),
            .multiplicand (req.opA),
            .pp           (ppComb[i])
        );
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ppSet <= '0;
        end else if (load) begin
            ppSet <= ppComb;       // Frozen while the pipe stalls
        end
    end

endmodule

`default_nettype wire

/* hdl/boothDigitEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

// Radix-4 Booth digit to partial product
// pp = digit * multiplicand * 4^idx, modulo 2^64
module boothDigitEncoder (
    input  wire boothArithPkg::boothGroupT grp,
    input  wire boothArithPkg::digitIdxT   idx,
    input  wire boothArithPkg::operandT    multiplicand,
    output boothArithPkg::ppT              pp
);

    localparam int extWidth = boothArithPkg::prodWidth - boothArithPkg::opWidth;

    logic                   isZero;     // Digit is 0
    logic                   isTwo;      // Magnitude is 2
    logic                   isNeg;      // Digit is negative
    logic [4:0]             shiftAmt;   // 2*idx plus one for magnitude two
    boothArithPkg::ppT      extended;
    boothArithPkg::ppT      shifted;

    // Booth decode of the three-bit group
    always_comb begin
        case (grp)
            3'b000, 3'b111: begin
                isZero = 1'b1;
                isTwo  = 1'b0;
            end
            3'b011, 3'b100: begin
                isZero = 1'b0;
                isTwo  = 1'b1;
            end
            default: begin          // 001, 010, 101, 110 give magnitude one
                isZero = 1'b0;
                isTwo  = 1'b0;
            end
        endcase
    end

    assign isNeg = grp[2];  // 111 is zero anyway

    // Low bit of 2*idx is always zero, so isTwo just fills it
    assign shiftAmt = {idx, isTwo};

    assign extended = {{extWidth{multiplicand[boothArithPkg::opWidth-1]}}, multiplicand};

    assign shifted = isZero ? '0 : (extended << shiftAmt);

    // Two's complement over the full 64 bits
    assign pp = isNeg ? (~shifted + 64'd1) : shifted;

endmodule

`default_nettype wire

/* hdl/mulPipePkg.sv */
`default_nettype none

// Bundles that move between the pipeline stages
package mulPipePkg;

    // Request payload
    typedef struct packed {
        boothArithPkg::operandT opA;    // Multiplicand
        boothArithPkg::operandT opB;    // Multiplier
    } mulReqT;

    // All partial products of one request, index 0 is the least significant digit
    typedef boothArithPkg::ppT [boothArithPkg::numPp-1:0] ppSetT;

    // Redundant sum/carry pair out of a 3:2 compressor
    typedef struct packed {
        boothArithPkg::productT sum;
        boothArithPkg::productT carry;  // Already shifted left by one
    } csaPairT;

    // Rows left after tree level three
    typedef struct packed {
        csaPairT                lvl3A;        // First level-3 compressor
        csaPairT                lvl3B;        // Second level-3 compressor
        boothArithPkg::productT carryL1Last;  // Carry of the fifth level-1 adder, shifted
        boothArithPkg::ppT      pp15;         // Top partial product, not yet reduced
    } midTreeT;

endpackage

`default_nettype wire

/* hdl/boothArithPkg.sv */
`default_nettype none

// Widths and plain vector types of the Booth multiplier datapath
package boothArithPkg;

    localparam int opWidth   = 32;      // Operand width
    localparam int prodWidth = 64;      // Full product width
    localparam int numPp     = 16;      // One partial product per radix-4 digit

    // Signed operand as seen on the request bus
    typedef logic signed [opWidth-1:0] operandT;

    // Product and every intermediate row of the tree
    typedef logic [prodWidth-1:0] productT;

    // Overlapping multiplier bits {b(2i+1), b(2i), b(2i-1)}
    typedef logic [2:0] boothGroupT;

    // Digit position, weight is 4^idx
    typedef logic [3:0] digitIdxT;

    // One sign-extended partial product
    typedef logic [prodWidth-1:0] ppT;

endpackage

`default_nettype wire
